//--- include/dispatch_defs.svh
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// Datapath widths
`define DISPATCH_WORD_W 32
`define DISPATCH_REG_IDX_W 5
`define DISPATCH_CMD_W 5
`define DISPATCH_GR_COUNT 32

// System register indices
`define SYSREG_CPUIDR 5'd0
`define SYSREG_COREIDR 5'd1
`define SYSREG_TIDR 5'd2
`define SYSREG_PCR 5'd4
`define SYSREG_SPR 5'd5
`define SYSREG_PSR 5'd6
`define SYSREG_PPSR 5'd11

// Identification and pc step
`define DISPATCH_CPU_ID 32'h0320_0101
`define DISPATCH_PC_STEP 32'd4
// Bits 6, 5 and 2 of the status word
`define PSR_IRQ_CLEAR_BITS 32'h0000_0064

`endif

//--- rtl/dispatch_pkg.sv
`include "dispatch_defs.svh"

// Pipeline datapath fields
package pipe_pkg;

	// Operand and pc word
	typedef logic [`DISPATCH_WORD_W-1:0] word_t;

	// General register index, also the low bits of source 1
	typedef logic [`DISPATCH_REG_IDX_W-1:0] reg_idx_t;

	// Command code, passed through to execute
	typedef logic [`DISPATCH_CMD_W-1:0] cmd_t;

endpackage

// System register file
package sysreg_pkg;

	// System register number
	typedef logic [`DISPATCH_REG_IDX_W-1:0] sysreg_idx_t;

	// Program status word
	typedef logic [`DISPATCH_WORD_W-1:0] psr_t;

endpackage

//--- rtl/wb_if.sv
interface wb_if;
	logic valid;
	pipe_pkg::word_t data;
	pipe_pkg::reg_idx_t destination;
	logic destination_sysreg;
	logic writeback;
	logic spr_writeback;
	pipe_pkg::word_t spr;

	// Register files commit on the strobe
	modport sink (
		input valid, data, destination, destination_sysreg,
		input writeback, spr_writeback, spr
	);

	// Forwarding in the same cycle
	modport snoop (
		input valid, data, destination, destination_sysreg,
		input writeback, spr_writeback, spr
	);
endinterface

//--- rtl/gr_file.sv
`include "dispatch_defs.svh"

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	wb_if.sink wb,
	input pipe_pkg::reg_idx_t rd0_idx,
	input pipe_pkg::reg_idx_t rd1_idx,
	output pipe_pkg::word_t rd0_data,
	output pipe_pkg::word_t rd1_data
);
	import pipe_pkg::*;

	word_t regs [`DISPATCH_GR_COUNT];
	logic wr_en;

	// General destinations only
	assign wr_en = wb.valid && wb.writeback && !wb.destination_sysreg;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `DISPATCH_GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Asynchronous read ports
	assign rd0_data = regs[rd0_idx];
	assign rd1_data = regs[rd1_idx];

endmodule

//--- rtl/sysreg_file.sv
`include "dispatch_defs.svh"

module sysreg_file #(
	parameter int unsigned CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	wb_if.sink wb,
	input logic irq_enter,
	input logic irq_return,
	input sysreg_pkg::sysreg_idx_t rd0_idx,
	input sysreg_pkg::sysreg_idx_t rd1_idx,
	input pipe_pkg::word_t pc,
	output pipe_pkg::word_t rd0_data,
	output pipe_pkg::word_t rd1_data,
	output sysreg_pkg::psr_t psr,
	output sysreg_pkg::psr_t ppsr,
	output pipe_pkg::word_t spr,
	output pipe_pkg::word_t tidr
);
	import pipe_pkg::*;
	import sysreg_pkg::*;

	word_t b_tidr;
	word_t b_spr;
	psr_t b_psr;
	psr_t b_ppsr;
	logic sys_wr;
	logic spr_pend;

	assign sys_wr = wb.valid && wb.writeback && wb.destination_sysreg;
	assign spr_pend = wb.valid && wb.spr_writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_tidr <= '0;
			b_spr <= '0;
			b_psr <= '0;
			b_ppsr <= '0;
		end else begin
			if (sys_wr && wb.destination == `SYSREG_TIDR) begin
				b_tidr <= wb.data;
			end
			// Stack pointer path wins over a normal write
			if (spr_pend) begin
				b_spr <= wb.spr;
			end else if (sys_wr && wb.destination == `SYSREG_SPR) begin
				b_spr <= wb.data;
			end
			// Interrupt entry saves PSR and masks it
			if (irq_enter) begin
				b_psr <= b_psr & ~`PSR_IRQ_CLEAR_BITS;
			end else if (irq_return) begin
				b_psr <= b_ppsr;
			end else if (sys_wr && wb.destination == `SYSREG_PSR) begin
				b_psr <= wb.data;
			end
			if (irq_enter) begin
				b_ppsr <= b_psr;
			end else if (sys_wr && wb.destination == `SYSREG_PPSR) begin
				b_ppsr <= wb.data;
			end
		end
	end

	function automatic word_t read_sysreg(input sysreg_idx_t idx);
		case (idx)
			`SYSREG_CPUIDR: return `DISPATCH_CPU_ID;
			`SYSREG_COREIDR: return word_t'(CORE_ID);
			`SYSREG_TIDR: return b_tidr;
			// Address of the instruction itself
			`SYSREG_PCR: return pc - `DISPATCH_PC_STEP;
			`SYSREG_SPR: return b_spr;
			`SYSREG_PSR: return b_psr;
			`SYSREG_PPSR: return b_ppsr;
			default: return '0;
		endcase
	endfunction

	assign rd0_data = read_sysreg(rd0_idx);
	assign rd1_data = read_sysreg(rd1_idx);

	assign psr = b_psr;
	assign ppsr = b_ppsr;
	assign spr = b_spr;
	assign tidr = b_tidr;

endmodule

//--- rtl/operand_fetch.sv
`include "dispatch_defs.svh"

module operand_fetch (
	wb_if.snoop wb,
	input pipe_pkg::reg_idx_t src0_idx,
	input pipe_pkg::reg_idx_t src1_idx,
	input logic src0_sysreg,
	input logic src1_sysreg,
	input logic src1_imm,
	input pipe_pkg::word_t src1_raw,
	input pipe_pkg::word_t gr0,
	input pipe_pkg::word_t gr1,
	input pipe_pkg::word_t sr0,
	input pipe_pkg::word_t sr1,
	output pipe_pkg::word_t src0,
	output pipe_pkg::word_t src1
);
	import pipe_pkg::*;

	logic hit0;
	logic hit1;
	word_t fwd0;
	word_t fwd1;

	// Hit flag on top of the forwarded word
	function automatic logic [`DISPATCH_WORD_W:0] forward(
		input reg_idx_t idx,
		input logic sysreg
	);
		if (!wb.valid) begin
			return '0;
		end
		if (sysreg) begin
			// PCR follows the instruction's own pc, nothing to forward
			if (idx == `SYSREG_PCR) begin
				return '0;
			end else if (idx == `SYSREG_SPR && wb.spr_writeback) begin
				return {1'b1, wb.spr};
			end else if (wb.writeback && wb.destination_sysreg && wb.destination == idx) begin
				return {1'b1, wb.data};
			end
			return '0;
		end
		if (wb.writeback && !wb.destination_sysreg && wb.destination == idx) begin
			return {1'b1, wb.data};
		end
		return '0;
	endfunction

	always_comb {hit0, fwd0} = forward(src0_idx, src0_sysreg);
	always_comb {hit1, fwd1} = forward(src1_idx, src1_sysreg);

	assign src0 = hit0 ? fwd0 : (src0_sysreg ? sr0 : gr0);

	// Immediate beats forwarding and both files
	assign src1 = src1_imm ? src1_raw : (hit1 ? fwd1 : (src1_sysreg ? sr1 : gr1));

endmodule

//--- rtl/dispatch_latch.sv
module dispatch_latch (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic prev_valid,
	input pipe_pkg::reg_idx_t prev_src0,
	input pipe_pkg::reg_idx_t prev_src1_ptr,
	input pipe_pkg::reg_idx_t prev_dest,
	input logic prev_dest_sysreg,
	input logic prev_writeback,
	input pipe_pkg::cmd_t prev_cmd,
	input pipe_pkg::word_t prev_pc,
	input pipe_pkg::word_t src0,
	input pipe_pkg::word_t src1,
	output logic next_valid,
	output pipe_pkg::word_t next_src0,
	output pipe_pkg::word_t next_src1,
	output pipe_pkg::reg_idx_t next_src0_ptr,
	output pipe_pkg::reg_idx_t next_src1_ptr,
	output pipe_pkg::reg_idx_t next_dest,
	output logic next_dest_sysreg,
	output logic next_writeback,
	output pipe_pkg::cmd_t next_cmd,
	output pipe_pkg::word_t next_pc
);
	logic b_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= 1'b0;
			next_src0 <= '0;
			next_src1 <= '0;
			next_src0_ptr <= '0;
			next_src1_ptr <= '0;
			next_dest <= '0;
			next_dest_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_cmd <= '0;
			next_pc <= '0;
		end else if (refresh) begin
			b_valid <= 1'b0;
			next_src0 <= '0;
			next_src1 <= '0;
			next_src0_ptr <= '0;
			next_src1_ptr <= '0;
			next_dest <= '0;
			next_dest_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_cmd <= '0;
			next_pc <= '0;
		end else if (!next_lock) begin
			b_valid <= prev_valid;
			next_src0 <= src0;
			next_src1 <= src1;
			next_src0_ptr <= prev_src0;
			next_src1_ptr <= prev_src1_ptr;
			next_dest <= prev_dest;
			next_dest_sysreg <= prev_dest_sysreg;
			next_writeback <= prev_writeback;
			next_cmd <= prev_cmd;
			next_pc <= prev_pc;
		end
	end

	// Execute sees nothing while it holds the lock
	assign next_valid = b_valid && !next_lock;

endmodule

//--- rtl/dispatch.sv
module dispatch #(
	parameter int unsigned CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic irq_enter,
	input logic irq_return,
	input logic prev_valid,
	input pipe_pkg::reg_idx_t prev_src0,
	input logic prev_src0_sysreg,
	input pipe_pkg::word_t prev_src1,
	input logic prev_src1_sysreg,
	input logic prev_src1_imm,
	input pipe_pkg::reg_idx_t prev_dest,
	input logic prev_dest_sysreg,
	input logic prev_writeback,
	input pipe_pkg::cmd_t prev_cmd,
	input pipe_pkg::word_t prev_pc,
	output logic prev_lock,
	input logic wb_valid,
	input pipe_pkg::word_t wb_data,
	input pipe_pkg::reg_idx_t wb_dest,
	input logic wb_dest_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input pipe_pkg::word_t wb_spr,
	output logic next_valid,
	output pipe_pkg::word_t next_src0,
	output pipe_pkg::word_t next_src1,
	output pipe_pkg::reg_idx_t next_src0_ptr,
	output pipe_pkg::reg_idx_t next_src1_ptr,
	output pipe_pkg::reg_idx_t next_dest,
	output logic next_dest_sysreg,
	output logic next_writeback,
	output pipe_pkg::cmd_t next_cmd,
	output pipe_pkg::word_t next_pc,
	output sysreg_pkg::psr_t sysreg_psr,
	output sysreg_pkg::psr_t sysreg_ppsr,
	output pipe_pkg::word_t sysreg_spr,
	output pipe_pkg::word_t sysreg_tidr,
	input logic next_lock
);
	import pipe_pkg::*;

	wb_if wb ();

	reg_idx_t src1_idx;
	word_t gr0;
	word_t gr1;
	word_t sr0;
	word_t sr1;
	word_t src0;
	word_t src1;

	assign wb.valid = wb_valid;
	assign wb.data = wb_data;
	assign wb.destination = wb_dest;
	assign wb.destination_sysreg = wb_dest_sysreg;
	assign wb.writeback = wb_writeback;
	assign wb.spr_writeback = wb_spr_writeback;
	assign wb.spr = wb_spr;

	// Register number sits in the low bits of source 1
	assign src1_idx = reg_idx_t'(prev_src1);

	assign prev_lock = next_lock;

	gr_file i_gr_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .wb(wb.sink),
		.rd0_idx(prev_src0), .rd1_idx(src1_idx),
		.rd0_data(gr0), .rd1_data(gr1)
	);

	sysreg_file #(.CORE_ID(CORE_ID)) i_sysreg_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .wb(wb.sink),
		.irq_enter(irq_enter), .irq_return(irq_return),
		.rd0_idx(prev_src0), .rd1_idx(src1_idx), .pc(prev_pc),
		.rd0_data(sr0), .rd1_data(sr1),
		.psr(sysreg_psr), .ppsr(sysreg_ppsr), .spr(sysreg_spr), .tidr(sysreg_tidr)
	);

	operand_fetch i_operand_fetch (
		.wb(wb.snoop),
		.src0_idx(prev_src0), .src1_idx(src1_idx),
		.src0_sysreg(prev_src0_sysreg), .src1_sysreg(prev_src1_sysreg),
		.src1_imm(prev_src1_imm), .src1_raw(prev_src1),
		.gr0(gr0), .gr1(gr1), .sr0(sr0), .sr1(sr1),
		.src0(src0), .src1(src1)
	);

	dispatch_latch i_latch (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.refresh(refresh), .next_lock(next_lock),
		.prev_valid(prev_valid), .prev_src0(prev_src0), .prev_src1_ptr(src1_idx),
		.prev_dest(prev_dest), .prev_dest_sysreg(prev_dest_sysreg),
		.prev_writeback(prev_writeback), .prev_cmd(prev_cmd), .prev_pc(prev_pc),
		.src0(src0), .src1(src1),
		.next_valid(next_valid), .next_src0(next_src0), .next_src1(next_src1),
		.next_src0_ptr(next_src0_ptr), .next_src1_ptr(next_src1_ptr),
		.next_dest(next_dest), .next_dest_sysreg(next_dest_sysreg),
		.next_writeback(next_writeback), .next_cmd(next_cmd), .next_pc(next_pc)
	);

endmodule

//--- sim/dispatch_asserts.sv
module dispatch_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic next_valid,
	input pipe_pkg::word_t next_src0,
	input pipe_pkg::word_t next_src1,
	input pipe_pkg::word_t next_pc
);
	int failures = 0;

	a_reset_valid: assert property (@(posedge iCLOCK) $rose(inRESET) |->
		!next_valid && next_src0 == '0 && next_src1 == '0 && next_pc == '0)
	else begin
		failures++;
		$error("latch is not clear in the first cycle after reset");
	end

	a_refresh_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		refresh |=> !next_valid)
	else begin
		failures++;
		$error("next_valid is high in the cycle after a refresh");
	end

	// Refresh wins over the lock
	a_lock_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock && !refresh |=> $stable(next_src0) && $stable(next_src1) && $stable(next_pc))
	else begin
		failures++;
		$error("latched fields changed while next_lock was high");
	end
endmodule

bind dispatch dispatch_asserts i_asserts (.*);

//--- sim/dispatch_checker.sv
module dispatch_checker (
	input logic iCLOCK,
	input logic [7:0] kind,
	input logic [7:0] name_idx,
	input pipe_pkg::word_t exp_src0,
	input pipe_pkg::word_t exp_src1,
	input logic exp_valid,
	input sysreg_pkg::psr_t exp_psr,
	input sysreg_pkg::psr_t exp_ppsr,
	input logic [53:0] exp_fields,
	input logic next_lock,
	input logic wb_valid,
	input logic wb_spr_writeback,
	input pipe_pkg::word_t wb_spr,
	input logic next_valid,
	input pipe_pkg::word_t next_src0,
	input pipe_pkg::word_t next_src1,
	input logic [53:0] fields,
	input logic prev_lock,
	input sysreg_pkg::psr_t sysreg_psr,
	input sysreg_pkg::psr_t sysreg_ppsr,
	input pipe_pkg::word_t sysreg_spr,
	input pipe_pkg::word_t sysreg_tidr
);
	int errors = 0;
	int checks = 0;

	function automatic string test_name(input logic [7:0] idx);
		case (idx)
			8'h00: return "reset";
			8'h01: return "gr_unwritten";
			8'h02: return "gr_read";
			8'h03: return "bypass";
			8'h04: return "imm_override";
			8'h05: return "sysreg_ids";
			8'h06: return "pcr";
			8'h07: return "spr_writeback";
			8'h08: return "spr_read";
			8'h09: return "irq_enter";
			8'h0a: return "irq_return";
			8'h0b: return "lock_hold";
			8'h0c: return "refresh";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %0h, actual %0h",
				test_name(name_idx), what, exp, act);
		end
	endtask

	// One cycle latency, so look just after the edge
	always @(posedge iCLOCK) begin
		#1;
		if (kind[0] === 1'b1) begin
			compare("next_src0", 64'(exp_src0), 64'(next_src0));
			compare("next_src1", 64'(exp_src1), 64'(next_src1));
		end
		if (kind[1] === 1'b1) begin
			compare("next_valid", 64'(exp_valid), 64'(next_valid));
			compare("prev_lock", 64'(next_lock), 64'(prev_lock));
		end
		if (kind[2] === 1'b1) begin
			compare("sysreg_psr", 64'(exp_psr), 64'(sysreg_psr));
			compare("sysreg_ppsr", 64'(exp_ppsr), 64'(sysreg_ppsr));
			// No case writes TIDR
			compare("sysreg_tidr", 64'd0, 64'(sysreg_tidr));
		end
		if (kind[3] === 1'b1) begin
			compare("other next fields", 64'd0, 64'(fields));
		end else if (kind[0] === 1'b1 && next_lock === 1'b0) begin
			compare("other next fields", 64'(exp_fields), 64'(fields));
		end
		// Stack pointer writeback wins over a normal write to SPR
		if (wb_valid === 1'b1 && wb_spr_writeback === 1'b1) begin
			compare("sysreg_spr", 64'(wb_spr), 64'(sysreg_spr));
		end
	end

	task automatic report(input int assert_failures, input int timeouts);
		$display("Summary: %0d checks, %0d mismatches, %0d assertion failures, %0d timeouts",
			checks, errors, assert_failures, timeouts);
	endtask
endmodule

//--- sim/tb_dispatch.sv
module tb_clock (
	output logic iCLOCK,
	output logic inRESET
);
	localparam int PERIOD = 100;

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#(PERIOD / 2) iCLOCK = ~iCLOCK;
		end
	end

	// Released on a falling edge after two cycles
	initial begin
		inRESET = 1'b0;
		#(2 * PERIOD) inRESET <= 1'b1;
	end
endmodule

module tb_dispatch;
	import pipe_pkg::*;
	import sysreg_pkg::*;

	localparam int CORE_ID = 3;
	localparam int REC_W = 14;
	localparam int MAX_REC = 32;
	localparam int RESET_WAIT = 10;
	localparam logic [31:0] END_KIND = 32'hff;

	logic iCLOCK;
	logic inRESET;
	logic refresh, irq_enter, irq_return, next_lock;
	logic prev_valid, prev_src0_sysreg, prev_src1_sysreg, prev_src1_imm;
	reg_idx_t prev_src0;
	word_t prev_src1;
	reg_idx_t prev_dest;
	logic prev_dest_sysreg, prev_writeback;
	cmd_t prev_cmd;
	word_t prev_pc;
	logic prev_lock;
	logic wb_valid, wb_dest_sysreg, wb_writeback, wb_spr_writeback;
	word_t wb_data;
	reg_idx_t wb_dest;
	word_t wb_spr;
	logic next_valid;
	word_t next_src0;
	word_t next_src1;
	reg_idx_t next_src0_ptr, next_src1_ptr, next_dest;
	logic next_dest_sysreg, next_writeback;
	cmd_t next_cmd;
	word_t next_pc;
	psr_t sysreg_psr;
	psr_t sysreg_ppsr;
	word_t sysreg_spr;
	word_t sysreg_tidr;

	logic [7:0] kind;
	logic [7:0] name_idx;
	word_t exp_src0;
	word_t exp_src1;
	logic exp_valid;
	psr_t exp_psr;
	psr_t exp_ppsr;
	logic [53:0] exp_fields;
	logic [31:0] rec_mem [0:REC_W*MAX_REC-1];
	int timeouts;

	tb_clock i_clock (.iCLOCK(iCLOCK), .inRESET(inRESET));

	dispatch #(.CORE_ID(CORE_ID)) i_dut (.*);

	// Instruction fields the latch passes through unchanged
	assign exp_fields = {prev_src0, prev_src1[4:0], prev_dest, prev_dest_sysreg,
		prev_writeback, prev_cmd, prev_pc};

	dispatch_checker i_chk (
		.*,
		.fields({next_src0_ptr, next_src1_ptr, next_dest, next_dest_sysreg,
			next_writeback, next_cmd, next_pc})
	);

	// Strobe bits of the ctl column
	task automatic drive_ctl(input logic [31:0] ctl);
		wb_valid = ctl[0];
		wb_writeback = ctl[1];
		wb_dest_sysreg = ctl[2];
		wb_spr_writeback = ctl[3];
		prev_valid = ctl[4];
		prev_src0_sysreg = ctl[5];
		prev_src1_sysreg = ctl[6];
		prev_src1_imm = ctl[7];
		refresh = ctl[8];
		next_lock = ctl[9];
		irq_enter = ctl[10];
		irq_return = ctl[11];
	endtask

	task automatic idle_inputs();
		kind = '0;
		name_idx = '0;
		drive_ctl('0);
		wb_dest = '0;
		wb_data = '0;
		wb_spr = '0;
		prev_src0 = '0;
		prev_src1 = '0;
		prev_pc = '0;
		prev_cmd = '0;
		prev_dest = '0;
		prev_dest_sysreg = 1'b0;
		prev_writeback = 1'b0;
	endtask

	task automatic apply_record(input int base);
		kind = rec_mem[base][7:0];
		name_idx = rec_mem[base+1][7:0];
		drive_ctl(rec_mem[base+2]);
		wb_dest = rec_mem[base+3][4:0];
		wb_data = rec_mem[base+4];
		wb_spr = rec_mem[base+5];
		prev_src0 = rec_mem[base+6][4:0];
		prev_src1 = rec_mem[base+7];
		prev_pc = rec_mem[base+8];
		exp_src0 = rec_mem[base+9];
		exp_src1 = rec_mem[base+10];
		exp_valid = rec_mem[base+11][0];
		exp_psr = rec_mem[base+12];
		exp_ppsr = rec_mem[base+13];
		// Command tags the record
		prev_cmd = rec_mem[base+1][4:0];
		// Destination fields reuse the writeback columns
		prev_dest = wb_dest;
		prev_dest_sysreg = wb_dest_sysreg;
		prev_writeback = wb_writeback;
	endtask

	initial begin
		int rec;
		int wait_cnt;
		idle_inputs();
		timeouts = 0;
		$readmemh("sim/dispatch_cases.txt", rec_mem);
		wait_cnt = 0;
		while (inRESET !== 1'b1 && wait_cnt < RESET_WAIT) begin
			@(negedge iCLOCK);
			wait_cnt++;
		end
		if (inRESET !== 1'b1) begin
			$display("Timeout: reset was never released");
			timeouts++;
		end else begin
			rec = 0;
			while (rec < MAX_REC && rec_mem[rec*REC_W] !== END_KIND) begin
				@(negedge iCLOCK);
				apply_record(rec * REC_W);
				rec++;
			end
			if (rec >= MAX_REC) begin
				$display("Timeout: no end marker found in the case file");
				timeouts++;
			end
		end
		@(negedge iCLOCK);
		idle_inputs();
		repeat (2) @(negedge iCLOCK);
		i_chk.report(i_dut.i_asserts.failures, timeouts);
		if (timeouts == 0 && i_chk.errors == 0 && i_dut.i_asserts.failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end
endmodule

//--- sources.f
+incdir+include
rtl/dispatch_pkg.sv
rtl/wb_if.sv
rtl/gr_file.sv
rtl/sysreg_file.sv
rtl/operand_fetch.sv
rtl/dispatch_latch.sv
rtl/dispatch.sv
sim/dispatch_asserts.sv
sim/dispatch_checker.sv
sim/tb_dispatch.sv

//--- Makefile
# Operand dispatch stage, Verilator flow

TOP = tb_dispatch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o vsim
	out="$$(./obj_dir/vsim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

//--- sim/dispatch_cases.txt
// kind name ctl wb_dest wb_data wb_spr src0 src1 pc exp_src0 exp_src1 exp_valid exp_psr exp_ppsr
// kind bit0 operands, bit1 valid, bit2 psr and ppsr, bit3 other fields zero; ff ends the list
f 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 13 3 1234abcd 0 7 7 100 0 0 1 0 0
3 2 10 0 0 0 3 3 104 1234abcd 1234abcd 1 0 0
3 3 13 9 55aa0009 0 9 9 108 55aa0009 55aa0009 1 0 0
3 4 93 9 77770009 0 9 9 10c 77770009 9 1 0 0
3 5 70 0 0 0 0 1 110 3200101 3 1 0 0
3 6 37 4 dead 0 4 3 200 1fc 1234abcd 1 0 0
3 7 7f 5 1111 8000f000 5 5 204 8000f000 8000f000 1 0 0
7 8 37 6 ff 0 5 0 208 8000f000 0 1 ff 0
7 9 400 0 0 0 0 0 0 0 0 0 9b ff
7 a 830 0 0 0 6 0 20c 9b 0 1 ff ff
3 b 90 0 0 0 3 42 210 1234abcd 42 1 ff ff
3 b 290 0 0 0 9 99 214 1234abcd 42 0 ff ff
3 b 90 0 0 0 9 99 218 77770009 99 1 ff ff
b c 110 0 0 0 3 3 21c 0 0 0 ff ff
b c 310 0 0 0 3 3 220 0 0 0 ff ff
ff
